/* Bender.yml */
package:
  name: accumulator_computer

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cpu_pkg.sv
      - hdl/mem_if.sv
      - hdl/alu.sv
      - hdl/main_memory.sv
      - hdl/cpu_core.sv
      - hdl/accumulator_computer.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - test/cpu_core_chk.sv
      - test/tb_accumulator_computer.sv

/* compile.f */
+incdir+hdl
hdl/cpu_pkg.sv
hdl/mem_if.sv
hdl/alu.sv
hdl/main_memory.sv
hdl/cpu_core.sv
hdl/accumulator_computer.sv
test/cpu_core_chk.sv
test/tb_accumulator_computer.sv

/* hdl/accumulator_computer.sv */
`timescale 1ns/1ns
`include "cpu_macros.svh"

// accumulator computer top
// core plus main memory, host port for program load and readback
module accumulator_computer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   host_we,
    input  logic [`MEM_ADDR_W-1:0] host_addr,
    input  logic [`WORD_W-1:0]     host_wdata,
    output logic [`WORD_W-1:0]     host_rdata,
    output logic                   running,
    output logic                   halted,
    output logic [`WORD_W-1:0]     acc
);

    // core to ram port
    mem_if bus ();

    cpu_core u_core (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .running    (running),
        .halted     (halted),
        .acc        (acc),
        .mem        (bus.core)
    );

    main_memory u_mem (
        .clk (clk),
        .mem (bus.memory)
    );

    // readback is the raw ram output
    // valid one cycle after host_addr while stopped
    assign host_rdata = bus.rdata;

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ns
`include "cpu_macros.svh"

// sixteen-function alu, purely combinational
// a is the accumulator, b the operand
module alu (
    input  cpu_pkg::alu_op_e    op,
    input  logic [`WORD_W-1:0]  a,
    input  logic [`WORD_W-1:0]  b,
    output logic [`WORD_W-1:0]  result
);

    // full product, only the low word is kept
    logic [2*`WORD_W-1:0] product;

    assign product = a * b;

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD:  result = a + b;
            cpu_pkg::ALU_SUB:  result = a - b;
            cpu_pkg::ALU_MUL:  result = product[`WORD_W-1:0];
            // divide by zero saturates to all ones
            cpu_pkg::ALU_DIV:  result = (b == '0) ? '1 : a / b;
            // single-bit shifts, zero fill
            cpu_pkg::ALU_SHL:  result = a << 1;
            cpu_pkg::ALU_SHR:  result = a >> 1;
            // rotates through the word, no carry
            cpu_pkg::ALU_ROL:  result = {a[`WORD_W-2:0], a[`WORD_W-1]};
            cpu_pkg::ALU_ROR:  result = {a[0], a[`WORD_W-1:1]};
            cpu_pkg::ALU_AND:  result = a & b;
            cpu_pkg::ALU_OR:   result = a | b;
            cpu_pkg::ALU_XOR:  result = a ^ b;
            cpu_pkg::ALU_NOR:  result = ~(a | b);
            cpu_pkg::ALU_NAND: result = ~(a & b);
            cpu_pkg::ALU_XNOR: result = ~(a ^ b);
            // compares are unsigned, result is 1 or 0
            cpu_pkg::ALU_GT:   result = (a > b) ? `WORD_W'(1) : '0;
            cpu_pkg::ALU_EQ:   result = (a == b) ? `WORD_W'(1) : '0;
            default:           result = '0;
        endcase
    end

endmodule

/* hdl/cpu_core.sv */
`timescale 1ns/1ns
`include "cpu_macros.svh"

// accumulator machine sequencer
// fetch, decode, execute, three cycles per instruction
module cpu_core (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   host_we,
    input  logic [`MEM_ADDR_W-1:0] host_addr,
    input  logic [`WORD_W-1:0]     host_wdata,
    output logic                   running,
    output logic                   halted,
    output logic [`WORD_W-1:0]     acc,
    mem_if.core                    mem
);

    cpu_pkg::core_state_e   state;
    logic [`MEM_ADDR_W-1:0] pc;
    // latched instruction, valid in EXECUTE
    cpu_pkg::instr_u        ir;
    // instruction word straight off the read port, valid in DECODE
    cpu_pkg::instr_u        fetched;

    // core-side memory request before the host mux
    logic [`MEM_ADDR_W-1:0] core_addr;
    logic                   core_we;

    logic [`WORD_W-1:0]     alu_b;
    logic [`WORD_W-1:0]     alu_result;
    logic [`WORD_W-1:0]     acc_next;
    logic [`MEM_ADDR_W-1:0] pc_next;

    // status comes straight from the state register
    assign running = (state == cpu_pkg::FETCH) ||
                     (state == cpu_pkg::DECODE) ||
                     (state == cpu_pkg::EXECUTE);
    assign halted  = (state == cpu_pkg::HALTED);

    assign fetched = mem.rdata;

    // memory request from the sequencer
    always_comb begin
        core_addr = pc;
        core_we   = 1'b0;
        if (state == cpu_pkg::DECODE) begin
            // operand access issued in the same cycle the opcode arrives
            case (fetched.mfmt.op)
                cpu_pkg::LOAD:  core_addr = fetched.mfmt.addr;
                cpu_pkg::STORE: begin
                    core_addr = fetched.mfmt.addr;
                    core_we   = 1'b1;
                end
                // ALU_M reaches only the bottom 256 words
                cpu_pkg::ALU_M: core_addr = `MEM_ADDR_W'(fetched.afmt.operand);
                default:        core_addr = pc;
            endcase
        end
    end

    // host owns the port whenever the machine is stopped
    assign mem.addr  = running ? core_addr : host_addr;
    assign mem.we    = running ? core_we : host_we;
    // STORE always writes the accumulator
    assign mem.wdata = running ? acc : host_wdata;

    // operand b, memory word or zero-extended immediate
    assign alu_b = (ir.afmt.op == cpu_pkg::ALU_M) ? mem.rdata : `WORD_W'(ir.afmt.operand);

    alu u_alu (
        .op     (ir.afmt.fn),
        .a      (acc),
        .b      (alu_b),
        .result (alu_result)
    );

    // execute-stage decode on the latched instruction
    always_comb begin
        acc_next = acc;
        // 12-bit pc wraps at the top of memory
        pc_next  = pc + 1'b1;
        case (ir.mfmt.op)
            cpu_pkg::LOAD:  acc_next = mem.rdata;
            cpu_pkg::ALU_M,
            cpu_pkg::ALU_I: acc_next = alu_result;
            cpu_pkg::LDI:   acc_next = `WORD_W'(ir.mfmt.addr);
            cpu_pkg::JUMP:  pc_next  = ir.mfmt.addr;
            cpu_pkg::JZ: begin
                // branch on the accumulator as it stands
                if (acc == '0) begin
                    pc_next = ir.mfmt.addr;
                end
            end
            // pc parks on the halt word
            cpu_pkg::HALT:  pc_next  = pc;
            default:        acc_next = acc;
        endcase
    end

    // state, pc and accumulator
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cpu_pkg::IDLE;
            pc    <= '0;
            acc   <= '0;
        end else begin
            case (state)
                cpu_pkg::IDLE,
                cpu_pkg::HALTED: begin
                    // start is only looked at while stopped
                    if (start) begin
                        state <= cpu_pkg::FETCH;
                        pc    <= '0;
                        acc   <= '0;
                    end
                end
                cpu_pkg::FETCH:  state <= cpu_pkg::DECODE;
                cpu_pkg::DECODE: state <= cpu_pkg::EXECUTE;
                cpu_pkg::EXECUTE: begin
                    acc <= acc_next;
                    pc  <= pc_next;
                    if (ir.mfmt.op == cpu_pkg::HALT) begin
                        state <= cpu_pkg::HALTED;
                    end else begin
                        state <= cpu_pkg::FETCH;
                    end
                end
                default: state <= cpu_pkg::IDLE;
            endcase
        end
    end

    // instruction register, loaded once per instruction
    always_ff @(posedge clk) begin
        if (state == cpu_pkg::DECODE) begin
            ir <= fetched;
        end
    end

endmodule

/* hdl/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data path and instruction word width
`define WORD_W 16

// main memory address width, in words
`define MEM_ADDR_W 12

// word count of main memory
// keep at 2**MEM_ADDR_W so the pc wrap lands on word 0
`define MEM_DEPTH 4096

`endif

/* hdl/cpu_pkg.sv */
`include "cpu_macros.svh"

package cpu_pkg;

    // top nibble of every instruction word
    // unlisted codes run as no-ops
    typedef enum logic [3:0] {
        LOAD  = 4'd0,
        STORE = 4'd1,
        ALU_M = 4'd2,
        ALU_I = 4'd3,
        JUMP  = 4'd4,
        JZ    = 4'd5,
        LDI   = 4'd6,
        HALT  = 4'd15
    } major_op_e;

    // alu function select
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_MUL,
        ALU_DIV,
        ALU_SHL,
        ALU_SHR,
        ALU_ROL,
        ALU_ROR,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_NAND,
        ALU_XNOR,
        ALU_GT,
        ALU_EQ
    } alu_op_e;

    // memory format carries a full address or the 12-bit LDI immediate
    typedef struct packed {
        major_op_e              op;
        logic [`MEM_ADDR_W-1:0] addr;
    } mem_fmt_t;

    // alu format with a low byte that is an address (ALU_M) or an immediate (ALU_I)
    typedef struct packed {
        major_op_e op;
        alu_op_e   fn;
        logic [7:0] operand;
    } alu_fmt_t;

    // one instruction word seen two ways
    typedef union packed {
        mem_fmt_t mfmt;
        alu_fmt_t afmt;
    } instr_u;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        EXECUTE,
        HALTED
    } core_state_e;

endpackage

/* hdl/main_memory.sv */
`timescale 1ns/1ns
`include "cpu_macros.svh"

// single-port synchronous ram
// one cycle read latency, rdata holds during a write
module main_memory (
    input logic    clk,
    mem_if.memory  mem
);

    // program and data share this array
    logic [`WORD_W-1:0] ram [0:`MEM_DEPTH-1];

    always_ff @(posedge clk) begin
        if (mem.we) begin
            // write cycle, read port left alone
            ram[mem.addr] <= mem.wdata;
        end else begin
            // registered read of the addressed word
            mem.rdata <= ram[mem.addr];
        end
    end

endmodule

/* hdl/mem_if.sv */
`timescale 1ns/1ns
`include "cpu_macros.svh"

// single port between core and main memory
// rdata is the word at the addr sampled on the previous edge
interface mem_if;

    logic [`MEM_ADDR_W-1:0] addr;
    logic [`WORD_W-1:0]     wdata;
    logic                   we;
    logic [`WORD_W-1:0]     rdata;

    // core side, also carries host traffic while stopped
    modport core (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    // ram side
    modport memory (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

/* test/cpu_core_chk.sv */
`timescale 1ns/1ns

// protocol checks on the core sequencer
// attached to every cpu_core by bind
module cpu_core_chk (
    input logic                 clk,
    input logic                 reset,
    input logic                 start,
    input logic                 host_we,
    input logic                 running,
    input logic                 halted,
    input cpu_pkg::core_state_e state,
    input logic                 we,
    input cpu_pkg::instr_u      fetched
);

    // status flags are exclusive
    a_status_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(running && halted))
        else $error("running and halted are high in the same cycle");

    // a ram write is host traffic while stopped, or the STORE operand cycle
    a_write_source: assert property (@(posedge clk) disable iff (reset)
        we |-> ((!running && host_we) ||
                (state == cpu_pkg::DECODE && fetched.mfmt.op == cpu_pkg::STORE)))
        else $error("memory write outside host access or STORE decode");

    // idle holds without start
    a_idle_holds: assert property (@(posedge clk) disable iff (reset)
        (state == cpu_pkg::IDLE && !start) |=> (state == cpu_pkg::IDLE))
        else $error("core left IDLE without a start pulse");

    // every run is opened by start on the previous edge
    a_run_needs_start: assert property (@(posedge clk) disable iff (reset)
        $rose(running) |-> $past(start))
        else $error("running rose without start");

endmodule

/* test/tb_accumulator_computer.sv */
`timescale 1ns/1ns
`include "cpu_macros.svh"

// testbench for the accumulator computer
// programs go in over the host port
// a reference interpreter predicts acc and memory
module tb_accumulator_computer;

    logic                   clk;
    logic                   reset;
    logic                   start;
    logic                   host_we;
    logic [`MEM_ADDR_W-1:0] host_addr;
    logic [`WORD_W-1:0]     host_wdata;
    logic [`WORD_W-1:0]     host_rdata;
    logic                   running;
    logic                   halted;
    logic [`WORD_W-1:0]     acc;

    // mirror of dut ram and the reference image after a run
    logic [`WORD_W-1:0]     image [0:`MEM_DEPTH-1];
    logic [`WORD_W-1:0]     ref_mem [0:`MEM_DEPTH-1];
    // host writes waiting to be issued
    logic [`MEM_ADDR_W-1:0] pend_addr [$];
    logic [`WORD_W-1:0]     pend_data [$];
    logic [15:0]            lfsr;
    logic                   ref_done;
    string                  test_name;
    int                     errors;
    int                     test_errors;
    int                     tests_passed;
    int                     tests_failed;

    accumulator_computer uut (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .running    (running),
        .halted     (halted),
        .acc        (acc)
    );

    bind cpu_core cpu_core_chk u_chk (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .host_we (host_we),
        .running (running),
        .halted  (halted),
        .state   (state),
        .we      (mem.we),
        .fetched (fetched)
    );

    always #5 clk = ~clk;

    // galois lfsr with taps 16 14 13 11
    // one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        repeat (n) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // alu behavior with a as the accumulator
    function automatic logic [`WORD_W-1:0] alu_model(input cpu_pkg::alu_op_e fn,
                                                     input logic [`WORD_W-1:0] a,
                                                     input logic [`WORD_W-1:0] b);
        case (fn)
            cpu_pkg::ALU_ADD:  return a + b;
            cpu_pkg::ALU_SUB:  return a - b;
            cpu_pkg::ALU_MUL:  return a * b;
            cpu_pkg::ALU_DIV:  return (b == 0) ? '1 : a / b;
            cpu_pkg::ALU_SHL:  return a << 1;
            cpu_pkg::ALU_SHR:  return a >> 1;
            cpu_pkg::ALU_ROL:  return (a << 1) | (a >> (`WORD_W - 1));
            cpu_pkg::ALU_ROR:  return (a >> 1) | (a << (`WORD_W - 1));
            cpu_pkg::ALU_AND:  return a & b;
            cpu_pkg::ALU_OR:   return a | b;
            cpu_pkg::ALU_XOR:  return a ^ b;
            cpu_pkg::ALU_NOR:  return ~(a | b);
            cpu_pkg::ALU_NAND: return ~(a & b);
            cpu_pkg::ALU_XNOR: return ~(a ^ b);
            cpu_pkg::ALU_GT:   return (a > b) ? 1 : 0;
            default:           return (a == b) ? 1 : 0;
        endcase
    endfunction

    // reference interpreter stepping one instruction at a time from pc 0
    function automatic logic [`WORD_W-1:0] interpret(input int step_limit);
        cpu_pkg::instr_u        ins;
        logic [`WORD_W-1:0]     a;
        logic [`MEM_ADDR_W-1:0] pc;
        logic [`MEM_ADDR_W-1:0] nxt;
        a = '0;
        pc = '0;
        ref_done = 1'b0;
        foreach (image[i])
            ref_mem[i] = image[i];
        for (int n = 0; n < step_limit && !ref_done; n++) begin
            ins = ref_mem[pc];
            nxt = pc + 1'b1;
            case (ins.mfmt.op)
                cpu_pkg::LOAD:  a = ref_mem[ins.mfmt.addr];
                cpu_pkg::STORE: ref_mem[ins.mfmt.addr] = a;
                // ALU_M operand address is the low byte into the bottom 256 words
                cpu_pkg::ALU_M: a = alu_model(ins.afmt.fn, a, ref_mem[ins.afmt.operand]);
                cpu_pkg::ALU_I: a = alu_model(ins.afmt.fn, a, `WORD_W'(ins.afmt.operand));
                cpu_pkg::LDI:   a = `WORD_W'(ins.mfmt.addr);
                cpu_pkg::JUMP:  nxt = ins.mfmt.addr;
                cpu_pkg::JZ:    nxt = (a == 0) ? ins.mfmt.addr : nxt;
                cpu_pkg::HALT:  ref_done = 1'b1;
                default:        ;
            endcase
            pc = nxt;
        end
        return a;
    endfunction

    function automatic logic [`WORD_W-1:0] mem_instr(input cpu_pkg::major_op_e op,
                                                     input int addr);
        cpu_pkg::instr_u w;
        w.mfmt.op = op;
        w.mfmt.addr = `MEM_ADDR_W'(addr);
        return w;
    endfunction

    function automatic logic [`WORD_W-1:0] alu_instr(input cpu_pkg::major_op_e op,
                                                     input cpu_pkg::alu_op_e fn,
                                                     input int operand);
        cpu_pkg::instr_u w;
        w.afmt.op = op;
        w.afmt.fn = fn;
        w.afmt.operand = 8'(operand);
        return w;
    endfunction

    // random straight-line instruction
    // data stays in words 128 to 319
    function automatic logic [`WORD_W-1:0] random_instr();
        logic [2:0]       sel;
        cpu_pkg::alu_op_e fn;
        logic [11:0]      r;
        sel = 3'(lfsr_bits(3));
        fn = cpu_pkg::alu_op_e'(4'(lfsr_bits(4)));
        r = 12'(lfsr_bits(12));
        case (sel)
            3'd0:       return mem_instr(cpu_pkg::LOAD, 128 + r[6:0] + r[11:7]);
            3'd1:       return mem_instr(cpu_pkg::STORE, 256 + r[5:0]);
            3'd2, 3'd7: return alu_instr(cpu_pkg::ALU_M, fn, 128 + r[6:0]);
            3'd3, 3'd6: return alu_instr(cpu_pkg::ALU_I, fn, r[7:0]);
            3'd4:       return mem_instr(cpu_pkg::LDI, r);
            // undefined major codes 7 to 14
            default:    return mem_instr(cpu_pkg::major_op_e'(4'd7 + r[2:0]), r);
        endcase
    endfunction

    function automatic void put(input int addr, input logic [`WORD_W-1:0] data);
        image[addr] = data;
        pend_addr.push_back(`MEM_ADDR_W'(addr));
        pend_data.push_back(data);
    endfunction

    task automatic flush_writes();
        while (pend_addr.size() > 0) begin
            @(posedge clk);
            host_we    <= 1'b1;
            host_addr  <= pend_addr.pop_front();
            host_wdata <= pend_data.pop_front();
        end
        @(posedge clk);
        host_we <= 1'b0;
    endtask

    // rdata follows the address by one edge
    task automatic read_word(input int addr, output logic [`WORD_W-1:0] data);
        @(posedge clk);
        host_addr <= `MEM_ADDR_W'(addr);
        @(posedge clk);
        @(negedge clk);
        data = host_rdata;
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic check_word(input string what, input logic [`WORD_W-1:0] expected,
                              input logic [`WORD_W-1:0] actual);
        if (actual !== expected) begin
            $display("Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error %s %s: expected %b, actual %b", test_name, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_region(input int lo, input int hi);
        logic [`WORD_W-1:0] d;
        for (int a = lo; a <= hi; a++) begin
            read_word(a, d);
            check_word($sformatf("mem[%0d]", a), image[a], d);
        end
    endtask

    task automatic wait_halted(input string what, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (halted !== 1'b1) begin
            if (n >= limit) begin
                abort_run($sformatf("timeout, %s %s never halted", test_name, what));
            end
            n++;
            @(negedge clk);
        end
    endtask

    // load pending words, run to HALT, compare, then adopt the reference image
    task automatic run_program(input string what, input bit poke);
        logic [`WORD_W-1:0] expected;
        flush_writes();
        expected = interpret(2000);
        if (!ref_done) begin
            $display("reference for %s %s did not reach HALT", test_name, what);
            errors++;
            test_errors++;
        end
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (poke) begin
            @(negedge clk);
            check_flag({what, " running"}, 1'b1, running);
            // host traffic while running goes nowhere
            repeat (4) begin
                @(posedge clk);
                host_we    <= 1'b1;
                host_addr  <= `MEM_ADDR_W'(400);
                host_wdata <= ~image[400];
            end
            @(posedge clk);
            host_we <= 1'b0;
        end
        wait_halted(what, 20000);
        check_word({what, " acc"}, expected, acc);
        check_flag({what, " running"}, 1'b0, running);
        foreach (image[i])
            image[i] = ref_mem[i];
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("%s passed", test_name);
        end else begin
            tests_failed++;
            $display("%s failed with %0d errors", test_name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        cpu_pkg::alu_op_e fn;
        logic [11:0]      a_val;
        logic [7:0]       scale;
        logic [7:0]       imm;
        clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        lfsr = 16'd40656;
        errors = 0;
        test_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        test_name = "reset_and_host";
        @(negedge clk);
        check_flag("running", 1'b0, running);
        check_flag("halted", 1'b0, halted);
        check_word("acc", '0, acc);
        // whole ram filled so no program reads an unwritten word
        for (int a = 0; a < `MEM_DEPTH; a++) begin
            put(a, `WORD_W'(lfsr_bits(`WORD_W)));
        end
        flush_writes();
        check_region(0, `MEM_DEPTH - 1);
        finish_test();

        test_name = "alu_ops";
        for (int k = 0; k < 32; k++) begin
            fn = cpu_pkg::alu_op_e'(4'(k % 16));
            a_val = 12'(lfsr_bits(12));
            scale = 8'(lfsr_bits(8));
            imm = 8'(lfsr_bits(8));
            if (k >= 16) begin
                // small acc under a large operand, zero divisor, equal operands
                a_val = a_val & 12'h00f;
                scale = 8'h00;
                imm = imm | 8'h80;
                if (fn == cpu_pkg::ALU_DIV) begin
                    imm = 8'h00;
                end
                if (fn == cpu_pkg::ALU_EQ) begin
                    imm = 8'(a_val);
                end
            end
            put(0, mem_instr(cpu_pkg::LDI, a_val));
            // first pass multiplies up into the top bits
            put(1, alu_instr(cpu_pkg::ALU_I, (k < 16) ? cpu_pkg::ALU_MUL : cpu_pkg::ALU_ADD,
                             scale));
            put(2, alu_instr(cpu_pkg::ALU_I, fn, imm));
            put(3, mem_instr(cpu_pkg::HALT, 0));
            run_program(fn.name(), 1'b0);
        end
        finish_test();

        test_name = "load_alu_store";
        for (int p = 0; p < 4; p++) begin
            for (int j = 0; j < 4; j++) begin
                a_val = 12'(lfsr_bits(7));
                put(3 * j, mem_instr(cpu_pkg::LOAD, 128 + a_val));
                fn = cpu_pkg::alu_op_e'(4'(lfsr_bits(4)));
                imm = 8'(lfsr_bits(7));
                put(3 * j + 1, alu_instr(cpu_pkg::ALU_M, fn, 128 + imm));
                put(3 * j + 2, mem_instr(cpu_pkg::STORE, 256 + 4 * p + j));
            end
            put(12, mem_instr(cpu_pkg::HALT, 0));
            run_program($sformatf("program %0d", p), 1'b0);
        end
        check_region(128, 271);
        finish_test();

        test_name = "countdown";
        put(0, mem_instr(cpu_pkg::LDI, 10 + lfsr_bits(3)));
        put(1, mem_instr(cpu_pkg::JZ, 5));
        put(2, alu_instr(cpu_pkg::ALU_I, cpu_pkg::ALU_SUB, 1));
        put(3, mem_instr(cpu_pkg::STORE, 320));
        put(4, mem_instr(cpu_pkg::JUMP, 1));
        put(5, alu_instr(cpu_pkg::ALU_I, cpu_pkg::ALU_ADD, 8'h5a));
        put(6, mem_instr(cpu_pkg::HALT, 0));
        run_program("first run", 1'b0);
        // parked until the next start
        for (int c = 0; c < 20; c++) begin
            @(negedge clk);
            check_flag("hold halted", 1'b1, halted);
            check_flag("hold running", 1'b0, running);
        end
        run_program("rerun", 1'b0);
        check_region(320, 320);
        finish_test();

        test_name = "host_lockout_random";
        // countdown program is still loaded and long enough to cover the pokes
        run_program("host write while running", 1'b1);
        check_region(400, 400);
        for (int p = 0; p < 4; p++) begin
            for (int j = 0; j < 12; j++) begin
                put(j, random_instr());
            end
            put(12, mem_instr(cpu_pkg::HALT, 0));
            run_program($sformatf("random %0d", p), 1'b0);
        end
        check_region(128, 319);
        finish_test();

        $display("%0d tests passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
